//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - logic/cache_geom_pkg.sv
  - logic/cache_req_pkg.sv
  - logic/cache_way_select.sv
  - logic/cache_tag_store.sv
  - logic/cache_replace_unit.sv
  - logic/cache_data_store.sv
  - logic/cache_subsystem.sv
  - target: test
    files:
      - verif/cache_subsystem_tb.sv

//--- logic/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_req_pkg::access_t  access,
    input  cache_geom_pkg::offset_t offset,
    input  logic                    write,
    input  logic                    strobe,
    input  cache_geom_pkg::word_t   wdata,
    output cache_geom_pkg::word_t   rdata
);

    cache_geom_pkg::word_t mem [cache_geom_pkg::num_sets]
                               [cache_geom_pkg::num_ways]
                               [cache_geom_pkg::words_per_line];
    logic allocate;

    assign allocate = strobe && write &&
                      (access.kind == cache_req_pkg::write_fill ||
                       access.kind == cache_req_pkg::write_evict);

    // the later assignment to the addressed word overrides the line clear.
    always_ff @(posedge clk) begin
        if (allocate) begin
            for (int i = 0; i < cache_geom_pkg::words_per_line; i++) begin
                mem[access.set][access.way][i] <= '0;
            end
        end
        if (strobe && write) begin
            mem[access.set][access.way][offset] <= wdata;
        end
    end

    // strobe is already qualified with the hit for reads.
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (strobe && !write) begin
            rdata <= mem[access.set][access.way][offset];
        end else begin
            rdata <= '0;
        end
    end

endmodule

//--- logic/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int num_sets       = 16;
    localparam int num_ways       = 4;
    localparam int words_per_line = 8;

    localparam int offset_width = $clog2(words_per_line);
    localparam int set_width    = $clog2(num_sets);
    localparam int way_width    = $clog2(num_ways);
    localparam int tag_width    = addr_width - set_width - offset_width;

    typedef logic [set_width-1:0]    set_idx_t;
    typedef logic [tag_width-1:0]    tag_t;
    typedef logic [way_width-1:0]    way_idx_t;
    typedef logic [offset_width-1:0] offset_t;
    typedef logic [word_width-1:0]   word_t;

    // one bit per way, used for hit and valid vectors.
    typedef logic [num_ways-1:0] way_vec_t;

    // tag sits in the high bits and the word offset in the low bits.
    typedef struct packed {
        tag_t     tag;
        set_idx_t set;
        offset_t  offset;
    } cache_addr_t;

endpackage

//--- logic/cache_replace_unit.sv
`timescale 1ns/1ps

module cache_replace_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_geom_pkg::set_idx_t set,
    input  logic                     evict,
    output cache_geom_pkg::way_idx_t victim_way
);

    // one round-robin pointer per set.
    cache_geom_pkg::way_idx_t ptr [cache_geom_pkg::num_sets];

    assign victim_way = ptr[set];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
                ptr[s] <= '0;
            end
        end else if (evict) begin
            ptr[set] <= ptr[set] + 1'b1; // wraps from the last way back to way 0.
        end
    end

endmodule

//--- logic/cache_req_pkg.sv
package cache_req_pkg;

    typedef struct packed {
        logic                      strobe;
        logic                      write;
        cache_geom_pkg::cache_addr_t addr;
        cache_geom_pkg::word_t     wdata;
    } cache_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  hit;
        cache_geom_pkg::word_t rdata;
    } cache_resp_t;

    // a write miss either fills a free way or evicts the victim way.
    typedef enum logic [1:0] {
        read_access = 2'b00,
        write_hit   = 2'b01,
        write_fill  = 2'b10,
        write_evict = 2'b11
    } access_kind_t;

    typedef struct packed {
        access_kind_t               kind;
        cache_geom_pkg::way_idx_t   way;
        cache_geom_pkg::set_idx_t   set;
    } access_t;

endpackage

//--- logic/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                      clk,
    input  logic                      reset,
    input  cache_req_pkg::cache_req_t req,
    output cache_req_pkg::cache_resp_t resp
);

    cache_geom_pkg::way_vec_t hits;
    cache_geom_pkg::way_vec_t valid_flags;
    cache_geom_pkg::way_idx_t victim_way;
    cache_req_pkg::access_t   access;
    cache_geom_pkg::word_t    rdata;
    logic                     hit;
    logic                     evict;
    logic                     write_strobe;
    logic                     data_strobe;
    logic                     valid_q;
    logic                     hit_q;

    assign write_strobe = req.strobe & req.write;
    assign data_strobe  = req.strobe & (req.write | hit); // read misses leave the store idle.

    cache_tag_store cache_tag_store_inst (
        .clk, .reset, .set(req.addr.set), .tag(req.addr.tag), .access,
        .write(write_strobe), .hits, .valid_flags
    );

    cache_way_select cache_way_select_inst (
        .clk, .reset, .req, .hits, .valid_flags, .victim_way, .access, .hit, .evict
    );

    cache_replace_unit cache_replace_unit_inst (
        .clk, .reset, .set(req.addr.set), .evict, .victim_way
    );

    cache_data_store cache_data_store_inst (
        .clk, .reset, .access, .offset(req.addr.offset), .write(req.write),
        .strobe(data_strobe), .wdata(req.wdata), .rdata
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            valid_q <= req.strobe;
            hit_q   <= hit;
        end
    end

    assign resp.valid = valid_q;
    assign resp.hit   = hit_q;
    assign resp.rdata = rdata;

    // the replacement pointer may only move on a write that misses.
    a_evict_on_write: assert property (@(posedge clk) disable iff (reset)
        evict |-> write_strobe && !hit);

endmodule

//--- logic/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_geom_pkg::set_idx_t set,
    input  cache_geom_pkg::tag_t     tag,
    input  cache_req_pkg::access_t   access,
    input  logic                     write,
    output cache_geom_pkg::way_vec_t hits,
    output cache_geom_pkg::way_vec_t valid_flags
);

    cache_geom_pkg::tag_t     tags    [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
    cache_geom_pkg::way_vec_t valid_q [cache_geom_pkg::num_sets];
    logic                     allocate;

    assign allocate = write && (access.kind == cache_req_pkg::write_fill ||
                                access.kind == cache_req_pkg::write_evict);

    // compare every way of the addressed set in parallel.
    always_comb begin
        valid_flags = valid_q[set];
        for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
            hits[w] = valid_flags[w] && (tags[set][w] == tag);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
            end
        end else if (allocate) begin
            valid_q[access.set][access.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            tags[access.set][access.way] <= tag; // the old tag is simply overwritten.
        end
    end

    // a tag is allocated only when no way of the set holds it yet.
    a_alloc_on_miss: assert property (@(posedge clk) disable iff (reset)
        allocate |-> hits == '0);

endmodule

//--- logic/cache_way_select.sv
`timescale 1ns/1ps

module cache_way_select (
    input  logic                     clk,
    input  logic                     reset,
    input  cache_req_pkg::cache_req_t req,
    input  cache_geom_pkg::way_vec_t hits,
    input  cache_geom_pkg::way_vec_t valid_flags,
    input  cache_geom_pkg::way_idx_t victim_way,
    output cache_req_pkg::access_t   access,
    output logic                     hit,
    output logic                     evict
);

    cache_geom_pkg::way_idx_t hit_way;
    cache_geom_pkg::way_idx_t free_way;
    logic                     any_hit;
    logic                     all_valid;

    // scan downwards so the lowest matching way wins.
    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int i = cache_geom_pkg::num_ways - 1; i >= 0; i--) begin
            if (hits[i]) hit_way = cache_geom_pkg::way_idx_t'(i);
            if (!valid_flags[i]) free_way = cache_geom_pkg::way_idx_t'(i);
        end
    end

    assign any_hit   = |hits;
    assign all_valid = &valid_flags;

    always_comb begin
        access.set  = req.addr.set;
        access.kind = cache_req_pkg::read_access;
        access.way  = hit_way; // reads use the hit way.
        if (req.strobe && req.write) begin
            if (any_hit) begin
                access.kind = cache_req_pkg::write_hit;
            end else if (!all_valid) begin
                access.kind = cache_req_pkg::write_fill;
                access.way  = free_way;
            end else begin
                access.kind = cache_req_pkg::write_evict;
                access.way  = victim_way;
            end
        end
    end

    assign hit   = req.strobe & any_hit;
    assign evict = req.strobe & req.write & ~any_hit & all_valid;

    // a tag may live in at most one way of a set.
    a_hits_onehot: assert property (@(posedge clk) disable iff (reset)
        req.strobe |-> $onehot0(hits));

    a_fill_free_way: assert property (@(posedge clk) disable iff (reset)
        access.kind == cache_req_pkg::write_fill |-> !valid_flags[access.way]);

endmodule

//--- project.f
logic/cache_geom_pkg.sv
logic/cache_req_pkg.sv
logic/cache_way_select.sv
logic/cache_tag_store.sv
logic/cache_replace_unit.sv
logic/cache_data_store.sv
logic/cache_subsystem.sv
verif/cache_subsystem_tb.sv

//--- verif/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb;

    typedef struct packed {
        logic                        strobe;
        logic                        write;
        cache_geom_pkg::cache_addr_t addr;
        cache_geom_pkg::word_t       wdata;
        logic                        exp_hit;
        cache_geom_pkg::word_t       exp_rdata;
    } stim_t;

    logic                       clk = 1'b0;
    logic                       reset;
    cache_req_pkg::cache_req_t  req;
    cache_req_pkg::cache_resp_t resp;
    stim_t                      stim_q[$];
    int                         errors = 0;
    int                         cycles = 0;
    int                         cycle_limit = 1000; // replaced once the table is built.

    cache_subsystem cache_subsystem_inst (.clk, .reset, .req, .resp);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic cache_geom_pkg::cache_addr_t make_addr(
        input cache_geom_pkg::tag_t tag, input cache_geom_pkg::set_idx_t set,
        input cache_geom_pkg::offset_t offset);
        cache_geom_pkg::cache_addr_t a;
        a.tag    = tag;
        a.set    = set;
        a.offset = offset;
        return a;
    endfunction

    task automatic add_read(input cache_geom_pkg::tag_t tag, input cache_geom_pkg::set_idx_t set,
                            input cache_geom_pkg::offset_t offset, input logic exp_hit,
                            input cache_geom_pkg::word_t exp_rdata);
        stim_q.push_back('{1'b1, 1'b0, make_addr(tag, set, offset), '0, exp_hit, exp_rdata});
    endtask

    // a write response never carries data.
    task automatic add_write(input cache_geom_pkg::tag_t tag, input cache_geom_pkg::set_idx_t set,
                             input cache_geom_pkg::offset_t offset,
                             input cache_geom_pkg::word_t wdata, input logic exp_hit);
        stim_q.push_back('{1'b1, 1'b1, make_addr(tag, set, offset), wdata, exp_hit, '0});
    endtask

    task automatic add_idle();
        stim_q.push_back('{1'b0, 1'b0, '0, '0, 1'b0, '0});
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_resp(input cache_req_pkg::cache_resp_t actual,
                              input cache_req_pkg::cache_resp_t expected, input int idx);
        if (actual !== expected) begin
            report_error($sformatf("entry %0d: got valid %b hit %b rdata %h, want %b %b %h",
                idx, actual.valid, actual.hit, actual.rdata,
                expected.valid, expected.hit, expected.rdata));
        end
    endtask

    task automatic check_idle(input cache_req_pkg::cache_resp_t actual, input int idx);
        if (actual.valid !== 1'b0) begin
            report_error($sformatf("entry %0d: resp.valid is %b without a request",
                idx, actual.valid));
        end
    endtask

    task automatic check_entry(input stim_t e, input int idx);
        cache_req_pkg::cache_resp_t expected;
        expected.valid = 1'b1;
        expected.hit   = e.exp_hit;
        expected.rdata = e.exp_rdata;
        if (e.strobe) check_resp(resp, expected, idx);
        else check_idle(resp, idx);
    endtask

    task automatic apply_entry(input stim_t e);
        req.strobe = e.strobe;
        req.write  = e.write;
        req.addr   = e.addr;
        req.wdata  = e.wdata;
    endtask

    initial begin
        req   = '0;
        reset = 1'b1;

        add_read(25'h123, 4'd5, 3'd2, 1'b0, '0); // cold cache misses everywhere.
        add_idle();
        add_read(25'h1abcdef, 4'd15, 3'd7, 1'b0, '0);
        add_idle();
        add_write(25'h10, 4'd3, 3'd4, 32'hdead_beef, 1'b0);
        add_read(25'h10, 4'd3, 3'd4, 1'b1, 32'hdead_beef);
        add_read(25'h10, 4'd3, 3'd0, 1'b1, '0); // rest of the line was cleared.
        add_read(25'h10, 4'd3, 3'd7, 1'b1, '0);
        add_write(25'h10, 4'd3, 3'd4, 32'h1234_5678, 1'b1);
        add_read(25'h10, 4'd3, 3'd4, 1'b1, 32'h1234_5678);
        for (int t = 0; t < 4; t++) begin
            add_write(cache_geom_pkg::tag_t'(32'ha0 + t), 4'd9, 3'd1, 32'h0a00 + t, 1'b0);
        end
        for (int t = 0; t < 4; t++) begin
            add_read(cache_geom_pkg::tag_t'(32'ha0 + t), 4'd9, 3'd1, 1'b1, 32'h0a00 + t);
        end
        // set 9 is full, so the victim pointer picks way 0 and then way 1.
        add_write(25'ha4, 4'd9, 3'd1, 32'h0a04, 1'b0);
        add_write(25'ha5, 4'd9, 3'd1, 32'h0a05, 1'b0);
        add_read(25'ha0, 4'd9, 3'd1, 1'b0, '0);
        add_read(25'ha1, 4'd9, 3'd1, 1'b0, '0);
        for (int t = 2; t < 6; t++) begin
            add_read(cache_geom_pkg::tag_t'(32'ha0 + t), 4'd9, 3'd1, 1'b1, 32'h0a00 + t);
        end
        add_read(25'h10, 4'd3, 3'd4, 1'b1, 32'h1234_5678);
        add_write(25'h11, 4'd3, 3'd0, 32'h5555_aaaa, 1'b0);
        add_read(25'h11, 4'd3, 3'd0, 1'b1, 32'h5555_aaaa);
        add_read(25'h10, 4'd3, 3'd4, 1'b1, 32'h1234_5678);
        add_idle();
        cycle_limit = 4 * stim_q.size() + 20;

        repeat (2) @(posedge clk);
        #2 reset = 1'b0;

        // each response is checked in the cycle that drives the next entry.
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            #2;
            if (i > 0) check_entry(stim_q[i-1], i - 1);
            apply_entry(stim_q[i]);
        end
        @(posedge clk);
        #2;
        check_entry(stim_q[stim_q.size()-1], stim_q.size() - 1);
        req = '0;

        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
